// File: files.f
+incdir+include
hw/dma_read_pkg.sv
hw/dma_fifo_sync.sv
hw/dma_axi_burst_reader.sv
hw/dma_fifo_to_stream.sv
hw/dma_read.sv
testbench/dma_read_properties.sv
testbench/axi_mem_model.sv
testbench/tb_dma_read.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_dma_read \
   -Mdir obj_dir -o sim_dma_read

output=$(./obj_dir/sim_dma_read +verilator+error+limit+1000)
echo "$output"

if echo "$output" | grep -qx "TEST PASS"; then
   exit 0
fi
exit 1

// File: testbench/tb_dma_read.sv
`timescale 1ns/1ns
`default_nettype none

`include "dma_read_consts.svh"

module tb_dma_read;

   import dma_read_pkg::*;

   localparam int TOTAL_WORDS    = 40 + 7 + 23 + 37 + 64 + 0 + 24;
   localparam int TIMEOUT_CYCLES = TOTAL_WORDS * 8 + 2000;

   logic                  clk_i;
   logic                  rst_n_i;
   logic                  r_start_i;
   dma_addr_t             r_addr_i;
   dma_xfer_t             r_length_i;
   dma_burst_t            r_max_len_i;
   logic                  r_busy_o;
   dma_xfer_t             r_remaining_o;
   dma_addr_t             m_axi_araddr_o;
   logic [`DMA_LEN_W-1:0] m_axi_arlen_o;
   logic                  m_axi_arvalid_o;
   logic                  m_axi_arready_i;
   dma_data_t             m_axi_rdata_i;
   logic                  m_axi_rlast_i;
   logic                  m_axi_rvalid_i;
   logic                  m_axi_rready_o;
   dma_data_t             axis_tdata_o;
   logic                  axis_tvalid_o;
   logic                  axis_tready_i = 1'b1;

   logic                  ar_gap = 1'b0;
   logic                  r_gap = 1'b0;
   logic                  gaps_on = 1'b0;
   logic                  bp_on = 1'b0;
   logic [15:0]           lfsr_q = 16'd6595;
   logic                  started = 1'b0;
   logic                  new_test = 1'b0;
   dma_addr_t             exp_base = '0;
   int                    exp_len = 0;
   dma_burst_t            cur_max = '0;
   dma_data_t             exp_word;
   int                    exp_remaining;
   dma_addr_t             ar_next = '0;
   int                    word_idx = 0;
   int                    ar_sum = 0;
   int                    busy_cycles = 0;
   int                    beat_cnt = 0;
   int                    word_cnt = 0;
   int                    prop_errors = 0;
   int                    check_errors = 0;
   int                    tests = 0;

   dma_read DUT (.*);

   axi_mem_model u_mem (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .ar_gap_i (ar_gap),
      .r_gap_i  (r_gap),
      .araddr_i (m_axi_araddr_o),
      .arlen_i  (m_axi_arlen_o),
      .arvalid_i(m_axi_arvalid_o),
      .arready_o(m_axi_arready_i),
      .rdata_o  (m_axi_rdata_i),
      .rlast_o  (m_axi_rlast_i),
      .rvalid_o (m_axi_rvalid_i),
      .rready_i (m_axi_rready_o)
   );

   // Fibonacci LFSR with taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic int error_total();
      return prop_errors + check_errors + DUT.u_props.fail_cnt;
   endfunction

   initial begin
      clk_i = 1'b0;
      forever #10 clk_i = ~clk_i;
   end

   // Stall bits from the LFSR
   // Ready is high one cycle in four under back-pressure
   always @(negedge clk_i) begin
      logic [15:0] s;
      logic        b_ar;
      logic        b_r;
      logic        b_t0;
      s = lfsr_next(lfsr_q);
      b_ar = s[0];
      s = lfsr_next(s);
      b_r = s[0];
      s = lfsr_next(s);
      b_t0 = s[0];
      s = lfsr_next(s);
      lfsr_q        <= s;
      ar_gap        <= gaps_on & b_ar;
      r_gap         <= gaps_on & b_r;
      axis_tready_i <= ~bp_on | (b_t0 & s[0]);
   end

   // Memory pattern for the next expected stream word
   assign exp_word = (exp_base + dma_addr_t'(word_idx) * 32'd4) ^ 32'hA5A5_0000;

   // Words not yet claimed by a launched burst
   assign exp_remaining = exp_len - ar_sum -
                          (m_axi_arvalid_o ? int'(m_axi_arlen_o) + 1 : 0);

   always @(posedge clk_i) begin
      if (new_test) begin
         word_idx    <= 0;
         ar_sum      <= 0;
         ar_next     <= exp_base;
         busy_cycles <= 0;
      end else begin
         if (axis_tvalid_o && axis_tready_i) word_idx <= word_idx + 1;
         if (r_busy_o) busy_cycles <= busy_cycles + 1;
         if (m_axi_arvalid_o && m_axi_arready_i) begin
            ar_sum  <= ar_sum + int'(m_axi_arlen_o) + 1;
            ar_next <= ar_next + (dma_addr_t'(m_axi_arlen_o) + 32'd1) * 32'd4;
         end
      end
      if (m_axi_rvalid_i && m_axi_rready_o) beat_cnt <= beat_cnt + 1;
      if (axis_tvalid_o && axis_tready_i) word_cnt <= word_cnt + 1;
   end

   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      axis_tvalid_o && axis_tready_i |-> axis_tdata_o == exp_word)
   else begin
      prop_errors++;
      $display("ERROR %0t axis_tdata_o expected %h got %h", $time,
               $sampled(exp_word), $sampled(axis_tdata_o));
   end

   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      axis_tvalid_o && axis_tready_i |-> word_idx < exp_len)
   else begin
      prop_errors++;
      $display("ERROR %0t axis_tvalid_o word count expected %0d got %0d", $time,
               $sampled(exp_len), $sampled(word_idx) + 1);
   end

   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      m_axi_arvalid_o && m_axi_arready_i |-> m_axi_araddr_o == ar_next)
   else begin
      prop_errors++;
      $display("ERROR %0t m_axi_araddr_o expected %h got %h", $time,
               $sampled(ar_next), $sampled(m_axi_araddr_o));
   end

   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      m_axi_arvalid_o && m_axi_arready_i |-> int'(m_axi_arlen_o) < int'(cur_max))
   else begin
      prop_errors++;
      $display("ERROR %0t m_axi_arlen_o expected below %0d got %0d", $time,
               $sampled(cur_max), $sampled(m_axi_arlen_o));
   end

   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      r_busy_o |-> int'(r_remaining_o) == exp_remaining)
   else begin
      prop_errors++;
      $display("ERROR %0t r_remaining_o expected %0d got %0d", $time,
               $sampled(exp_remaining), $sampled(r_remaining_o));
   end

   // FIFO depth plus the two stream registers
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      m_axi_rvalid_i && m_axi_rready_o |-> beat_cnt - word_cnt < 18)
   else begin
      prop_errors++;
      $display("ERROR %0t m_axi_rready_o outstanding expected below 18 got %0d", $time,
               $sampled(beat_cnt) - $sampled(word_cnt));
   end

   assert property (@(posedge clk_i)
      !started |-> !(r_busy_o || m_axi_arvalid_o || m_axi_rready_o || axis_tvalid_o))
   else begin
      prop_errors++;
      $display("ERROR %0t control outputs expected 0000 got %b%b%b%b", $time,
               $sampled(r_busy_o), $sampled(m_axi_arvalid_o),
               $sampled(m_axi_rready_o), $sampled(axis_tvalid_o));
   end

   task automatic run_transfer(input string name, input dma_addr_t addr, input dma_xfer_t len,
                               input dma_burst_t max_len, input logic bp,
                               input logic restart);
      int err0;
      err0 = error_total();
      @(negedge clk_i);
      exp_base    = addr;
      exp_len     = int'(len);
      cur_max     = max_len;
      gaps_on    <= bp;
      bp_on      <= bp;
      r_addr_i    = addr;
      r_length_i  = len;
      r_max_len_i = max_len;
      r_start_i   = 1'b1;
      new_test    = 1'b1;
      started     = 1'b1;
      @(negedge clk_i);
      r_start_i = 1'b0;
      new_test  = 1'b0;
      if (restart) begin
         // Lands in the middle of the running transfer
         repeat (6) @(negedge clk_i);
         r_addr_i   = addr + 32'h0000_4000;
         r_length_i = len + 16'd10;
         r_start_i  = 1'b1;
         @(negedge clk_i);
         r_start_i = 1'b0;
      end
      while (r_busy_o || word_idx < exp_len) @(negedge clk_i);
      assert (ar_sum == exp_len) else begin
         check_errors++;
         $display("ERROR %0t burst length sum expected %0d got %0d", $time, exp_len, ar_sum);
      end
      if (len == '0) begin
         assert (busy_cycles == 2) else begin
            check_errors++;
            $display("ERROR %0t r_busy_o cycles expected 2 got %0d", $time, busy_cycles);
         end
      end
      tests++;
      $display("%s: %0d words, %0d errors", name, word_idx, error_total() - err0);
   endtask

   initial begin
      rst_n_i     = 1'b0;
      r_start_i   = 1'b0;
      r_addr_i    = '0;
      r_length_i  = '0;
      r_max_len_i = dma_burst_t'(1);
      repeat (5) @(posedge clk_i);
      @(negedge clk_i);
      rst_n_i = 1'b1;
      repeat (3) @(negedge clk_i);
      tests++;
      $display("reset: outputs idle, %0d errors", error_total());
      run_transfer("data", 32'h0000_1000, 16'd40, 5'd16, 1'b0, 1'b0);
      run_transfer("split max 1", 32'h0000_2000, 16'd7, 5'd1, 1'b0, 1'b0);
      run_transfer("split max 5", 32'h0000_3004, 16'd23, 5'd5, 1'b0, 1'b0);
      run_transfer("split max 16", 32'h0000_4010, 16'd37, 5'd16, 1'b0, 1'b0);
      run_transfer("back-pressure", 32'h0000_8000, 16'd64, 5'd8, 1'b1, 1'b0);
      run_transfer("zero length", 32'h0000_6000, 16'd0, 5'd4, 1'b0, 1'b0);
      run_transfer("start while busy", 32'h0000_5000, 16'd24, 5'd4, 1'b0, 1'b1);
      $display("summary: %0d tests, %0d words, %0d errors", tests, word_cnt, error_total());
      if (error_total() == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

   initial begin
      int cycle_cnt;
      cycle_cnt = 0;
      while (cycle_cnt < TIMEOUT_CYCLES) begin
         @(posedge clk_i);
         cycle_cnt++;
      end
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: testbench/axi_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

`include "dma_read_consts.svh"

module axi_mem_model (
   input  wire                          clk_i,
   input  wire                          rst_n_i,
   // Random stall requests
   input  wire                          ar_gap_i,
   input  wire                          r_gap_i,
   // AXI read address channel
   input  wire dma_read_pkg::dma_addr_t araddr_i,
   input  wire [`DMA_LEN_W-1:0]         arlen_i,
   input  wire                          arvalid_i,
   output logic                         arready_o,
   // AXI read data channel
   output dma_read_pkg::dma_data_t      rdata_o,
   output logic                         rlast_o,
   output logic                         rvalid_o,
   input  wire                          rready_i
);

   import dma_read_pkg::*;

   dma_addr_t burst_addr [$];
   int        burst_len [$];
   int        beat_q = 0;
   logic      r_taken = 1'b0;

   // Bookkeeping of accepted requests and beats
   always @(posedge clk_i) begin
      r_taken <= rvalid_o && rready_i;
      if (arvalid_i && arready_o) begin
         burst_addr.push_back(araddr_i);
         burst_len.push_back(int'(arlen_i) + 1);
      end
      if (rvalid_o && rready_i) begin
         if (rlast_o) begin
            void'(burst_addr.pop_front());
            void'(burst_len.pop_front());
            beat_q <= 0;
         end else begin
            beat_q <= beat_q + 1;
         end
      end
   end

   // Outputs change on the falling edge only
   always @(negedge clk_i) begin
      if (!rst_n_i) begin
         arready_o <= 1'b0;
         rvalid_o  <= 1'b0;
         rlast_o   <= 1'b0;
      end else begin
         arready_o <= ~ar_gap_i;
         // A beat on offer stays until taken
         if (!rvalid_o || r_taken) begin
            if (burst_addr.size() > 0 && !r_gap_i) begin
               rvalid_o <= 1'b1;
               rdata_o  <= (burst_addr[0] + dma_addr_t'(beat_q) * 32'd4) ^ 32'hA5A5_0000;
               rlast_o  <= (beat_q == burst_len[0] - 1);
            end else begin
               rvalid_o <= 1'b0;
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: testbench/dma_read_properties.sv
`timescale 1ns/1ns
`default_nettype none

`include "dma_read_consts.svh"

module dma_read_properties (
   input wire                           clk_i,
   input wire                           rst_n_i,
   input wire dma_read_pkg::dma_burst_t r_max_len_i,
   input wire                           r_busy_o,
   input wire dma_read_pkg::dma_addr_t  m_axi_araddr_o,
   input wire [`DMA_LEN_W-1:0]          m_axi_arlen_o,
   input wire                           m_axi_arvalid_o,
   input wire                           m_axi_arready_i,
   input wire                           m_axi_rready_o,
   input wire dma_read_pkg::dma_data_t  axis_tdata_o,
   input wire                           axis_tvalid_o,
   input wire                           axis_tready_i
);

   import dma_read_pkg::*;

   int fail_cnt = 0;

   // Address phase holds until ARREADY
   ar_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      m_axi_arvalid_o && !m_axi_arready_i |=>
         m_axi_arvalid_o && $stable(m_axi_araddr_o) && $stable(m_axi_arlen_o))
   else begin
      $error("AR request changed or dropped before ARREADY");
      fail_cnt++;
   end

   stream_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      axis_tvalid_o && !axis_tready_i |=> axis_tvalid_o && $stable(axis_tdata_o))
   else begin
      $error("stream word changed or dropped while stalled");
      fail_cnt++;
   end

   ar_len_limit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      m_axi_arvalid_o |-> dma_burst_t'(m_axi_arlen_o) < r_max_len_i)
   else begin
      $error("burst longer than the maximum burst length");
      fail_cnt++;
   end

   // Outputs stay idle while reset is held
   reset_idle: assert property (@(posedge clk_i)
      !rst_n_i |-> !(r_busy_o || m_axi_arvalid_o || m_axi_rready_o || axis_tvalid_o))
   else begin
      $error("control output high during reset");
      fail_cnt++;
   end

endmodule

bind dma_read dma_read_properties u_props (.*);

`default_nettype wire

// File: hw/dma_read.sv
`timescale 1ns/1ns
`default_nettype none

`include "dma_read_consts.svh"

module dma_read (
   input  wire                           clk_i,
   input  wire                           rst_n_i,
   // Transfer control
   input  wire                           r_start_i,
   input  wire dma_read_pkg::dma_addr_t  r_addr_i,
   input  wire dma_read_pkg::dma_xfer_t  r_length_i,
   input  wire dma_read_pkg::dma_burst_t r_max_len_i,
   output logic                          r_busy_o,
   output dma_read_pkg::dma_xfer_t       r_remaining_o,
   // AXI read address channel
   output dma_read_pkg::dma_addr_t       m_axi_araddr_o,
   output logic [`DMA_LEN_W-1:0]         m_axi_arlen_o,
   output logic                          m_axi_arvalid_o,
   input  wire                           m_axi_arready_i,
   // AXI read data channel
   input  wire dma_read_pkg::dma_data_t  m_axi_rdata_i,
   input  wire                           m_axi_rlast_i,
   input  wire                           m_axi_rvalid_i,
   output logic                          m_axi_rready_o,
   // Output stream
   output dma_read_pkg::dma_data_t       axis_tdata_o,
   output logic                          axis_tvalid_o,
   input  wire                           axis_tready_i
);

   import dma_read_pkg::*;

   localparam dma_burst_t FIFO_DEPTH = dma_burst_t'(1 << `DMA_LEN_W);

   dma_sched_state_t state_q;
   dma_sched_state_t state_d;
   dma_xfer_t        remaining_q;
   dma_xfer_t        remaining_d;
   dma_addr_t        burst_addr_q;
   dma_addr_t        burst_addr_d;
   dma_burst_t       max_len_q;
   logic             first_q;
   logic             start_ok;
   logic             last_beat;

   dma_burst_t       fifo_level;
   dma_burst_t       free_space;
   dma_burst_t       burst_len;
   logic             start_burst;
   logic             reader_busy;

   logic             fifo_wen;
   dma_data_t        fifo_wdata;
   logic             fifo_full;
   logic             fifo_ren;
   dma_data_t        fifo_rdata;
   logic             fifo_empty;

   assign start_ok   = r_start_i & (state_q == SCHED_IDLE);
   assign last_beat  = m_axi_rvalid_i & m_axi_rready_o & m_axi_rlast_i;
   assign free_space = FIFO_DEPTH - fifo_level;

   always_comb begin
      state_d      = state_q;
      remaining_d  = remaining_q;
      burst_addr_d = burst_addr_q;
      start_burst  = 1'b0;
      burst_len    = '0;

      case (state_q)
         SCHED_IDLE: begin
            if (start_ok) begin
               remaining_d  = r_length_i;
               burst_addr_d = r_addr_i;
               state_d      = SCHED_RUN;
            end
         end
         SCHED_RUN: begin
            if (remaining_q == '0) begin
               // Wait out the final beat; a zero length stays one extra cycle
               if (!first_q && (!reader_busy || last_beat)) begin
                  state_d = SCHED_IDLE;
               end
            end else if (!reader_busy) begin
               if ((remaining_q <= dma_xfer_t'(free_space)) &&
                   (remaining_q <= dma_xfer_t'(max_len_q))) begin
                  // Tail of the transfer fits in one burst
                  burst_len = dma_burst_t'(remaining_q);
               end else if (free_space >= max_len_q) begin
                  burst_len = max_len_q;
               end

               if (burst_len != '0) begin
                  start_burst  = 1'b1;
                  remaining_d  = remaining_q - dma_xfer_t'(burst_len);
                  burst_addr_d = burst_addr_q + (dma_addr_t'(burst_len) << 2);
               end
            end
         end
         default: state_d = SCHED_IDLE;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q      <= SCHED_IDLE;
         remaining_q  <= '0;
         burst_addr_q <= '0;
         first_q      <= 1'b0;
      end else begin
         state_q      <= state_d;
         remaining_q  <= remaining_d;
         burst_addr_q <= burst_addr_d;
         first_q      <= start_ok;
      end
   end

   // Max burst length is fixed for the whole transfer
   always_ff @(posedge clk_i) begin
      if (start_ok) begin
         max_len_q <= r_max_len_i;
      end
   end

   assign r_busy_o      = (state_q == SCHED_RUN);
   assign r_remaining_o = remaining_q;

   dma_axi_burst_reader u_reader (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .start_i        (start_burst),
      .addr_i         (burst_addr_q),
      .len_i          (burst_len),
      .busy_o         (reader_busy),
      .m_axi_araddr_o (m_axi_araddr_o),
      .m_axi_arlen_o  (m_axi_arlen_o),
      .m_axi_arvalid_o(m_axi_arvalid_o),
      .m_axi_arready_i(m_axi_arready_i),
      .m_axi_rdata_i  (m_axi_rdata_i),
      .m_axi_rlast_i  (m_axi_rlast_i),
      .m_axi_rvalid_i (m_axi_rvalid_i),
      .m_axi_rready_o (m_axi_rready_o),
      .fifo_full_i    (fifo_full),
      .fifo_wen_o     (fifo_wen),
      .fifo_wdata_o   (fifo_wdata)
   );

   dma_fifo_sync u_fifo (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .w_en_i   (fifo_wen),
      .w_data_i (fifo_wdata),
      .w_full_o (fifo_full),
      .r_en_i   (fifo_ren),
      .r_data_o (fifo_rdata),
      .r_empty_o(fifo_empty),
      .level_o  (fifo_level)
   );

   dma_fifo_to_stream u_stream (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .fifo_empty_i (fifo_empty),
      .fifo_read_o  (fifo_ren),
      .fifo_rdata_i (fifo_rdata),
      .axis_tdata_o (axis_tdata_o),
      .axis_tvalid_o(axis_tvalid_o),
      .axis_tready_i(axis_tready_i)
   );

endmodule

`default_nettype wire

// File: hw/dma_fifo_to_stream.sv
`timescale 1ns/1ns
`default_nettype none

module dma_fifo_to_stream (
   input  wire                          clk_i,
   input  wire                          rst_n_i,
   // FIFO read port
   input  wire                          fifo_empty_i,
   output logic                         fifo_read_o,
   input  wire dma_read_pkg::dma_data_t fifo_rdata_i,
   // Output stream
   output dma_read_pkg::dma_data_t      axis_tdata_o,
   output logic                         axis_tvalid_o,
   input  wire                          axis_tready_i
);

   import dma_read_pkg::*;

   // The FIFO read register is the output slot
   // out_v_q marks that it holds a word not yet sent
   logic      out_v_q;
   logic      hold_v_q;
   dma_data_t hold_q;
   logic      pop;
   logic      spill;

   // Hold always carries the older word
   assign axis_tvalid_o = hold_v_q | out_v_q;
   assign axis_tdata_o  = hold_v_q ? hold_q : fifo_rdata_i;
   assign pop           = axis_tvalid_o & axis_tready_i;

   // A read is safe whenever hold is free
   assign fifo_read_o = ~fifo_empty_i & ~hold_v_q;

   // New read would overwrite an unsent output word
   assign spill = fifo_read_o & out_v_q & ~pop;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         out_v_q  <= 1'b0;
         hold_v_q <= 1'b0;
      end else if (hold_v_q) begin
         if (pop) begin
            hold_v_q <= 1'b0;
         end
      end else if (fifo_read_o) begin
         out_v_q <= 1'b1;
         if (spill) begin
            hold_v_q <= 1'b1;
         end
      end else if (pop) begin
         out_v_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (spill) begin
         hold_q <= fifo_rdata_i;
      end
   end

endmodule

`default_nettype wire

// File: hw/dma_axi_burst_reader.sv
`timescale 1ns/1ns
`default_nettype none

`include "dma_read_consts.svh"

module dma_axi_burst_reader (
   input  wire                           clk_i,
   input  wire                           rst_n_i,
   // Burst request from the scheduler
   input  wire                           start_i,
   input  wire dma_read_pkg::dma_addr_t  addr_i,
   input  wire dma_read_pkg::dma_burst_t len_i,
   output logic                          busy_o,
   // AXI read address channel
   output dma_read_pkg::dma_addr_t       m_axi_araddr_o,
   output logic [`DMA_LEN_W-1:0]         m_axi_arlen_o,
   output logic                          m_axi_arvalid_o,
   input  wire                           m_axi_arready_i,
   // AXI read data channel
   input  wire dma_read_pkg::dma_data_t  m_axi_rdata_i,
   input  wire                           m_axi_rlast_i,
   input  wire                           m_axi_rvalid_i,
   output logic                          m_axi_rready_o,
   // FIFO write port
   input  wire                           fifo_full_i,
   output logic                          fifo_wen_o,
   output dma_read_pkg::dma_data_t       fifo_wdata_o
);

   import dma_read_pkg::*;

   dma_reader_state_t     state_q;
   dma_reader_state_t     state_d;
   dma_addr_t             addr_q;
   logic [`DMA_LEN_W-1:0] arlen_q;
   dma_burst_t            len_m1;
   logic                  accept;
   logic                  beat;

   assign accept = start_i & (state_q == RD_IDLE);
   assign len_m1 = len_i - 1'b1;
   assign beat   = m_axi_rvalid_i & m_axi_rready_o;

   always_comb begin
      state_d = state_q;
      case (state_q)
         RD_IDLE: begin
            if (start_i) begin
               state_d = RD_ADDR;
            end
         end
         RD_ADDR: begin
            if (m_axi_arready_i) begin
               state_d = RD_DATA;
            end
         end
         RD_DATA: begin
            if (beat && m_axi_rlast_i) begin
               state_d = RD_IDLE;
            end
         end
         default: state_d = RD_IDLE;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= RD_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // Address and length stay put for the whole AR phase
   always_ff @(posedge clk_i) begin
      if (accept) begin
         addr_q  <= addr_i;
         arlen_q <= len_m1[`DMA_LEN_W-1:0];
      end
   end

   assign busy_o          = (state_q != RD_IDLE);
   assign m_axi_araddr_o  = addr_q;
   assign m_axi_arlen_o   = arlen_q;
   assign m_axi_arvalid_o = (state_q == RD_ADDR);

   // Beats go straight into the FIFO
   assign m_axi_rready_o = (state_q == RD_DATA) & ~fifo_full_i;
   assign fifo_wen_o     = beat;
   assign fifo_wdata_o   = m_axi_rdata_i;

endmodule

`default_nettype wire

// File: hw/dma_fifo_sync.sv
`timescale 1ns/1ns
`default_nettype none

`include "dma_read_consts.svh"

module dma_fifo_sync (
   input  wire                           clk_i,
   input  wire                           rst_n_i,
   // Write port
   input  wire                           w_en_i,
   input  wire dma_read_pkg::dma_data_t  w_data_i,
   output logic                          w_full_o,
   // Read port
   input  wire                           r_en_i,
   output dma_read_pkg::dma_data_t       r_data_o,
   output logic                          r_empty_o,
   // Number of stored words
   output dma_read_pkg::dma_burst_t      level_o
);

   import dma_read_pkg::*;

   localparam dma_burst_t DEPTH = dma_burst_t'(1 << `DMA_LEN_W);

   dma_data_t             mem_q [0:DEPTH-1];
   logic [`DMA_LEN_W-1:0] wptr_q;
   logic [`DMA_LEN_W-1:0] rptr_q;
   dma_burst_t            level_q;
   logic                  wr_ok;
   logic                  rd_ok;

   // Overflow and underflow requests are dropped
   assign wr_ok = w_en_i & ~w_full_o;
   assign rd_ok = r_en_i & ~r_empty_o;

   assign w_full_o  = (level_q == DEPTH);
   assign r_empty_o = (level_q == '0);
   assign level_o   = level_q;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wptr_q  <= '0;
         rptr_q  <= '0;
         level_q <= '0;
      end else begin
         if (wr_ok) begin
            wptr_q <= wptr_q + 1'b1;
         end
         if (rd_ok) begin
            rptr_q <= rptr_q + 1'b1;
         end
         case ({wr_ok, rd_ok})
            2'b10: level_q <= level_q + 1'b1;
            2'b01: level_q <= level_q - 1'b1;
            default: ;
         endcase
      end
   end

   // Storage and registered read data
   always_ff @(posedge clk_i) begin
      if (wr_ok) begin
         mem_q[wptr_q] <= w_data_i;
      end
      if (rd_ok) begin
         r_data_o <= mem_q[rptr_q];
      end
   end

endmodule

`default_nettype wire

// File: hw/dma_read_pkg.sv
`default_nettype none

`include "dma_read_consts.svh"

package dma_read_pkg;

   typedef logic [`DMA_ADDR_W-1:0] dma_addr_t;
   typedef logic [`DMA_DATA_W-1:0] dma_data_t;

   // Burst length in beats or FIFO level, one bit wider than ARLEN
   typedef logic [`DMA_LEN_W:0] dma_burst_t;

   typedef logic [`DMA_RLEN_W-1:0] dma_xfer_t;

   typedef enum logic {
      SCHED_IDLE,
      SCHED_RUN
   } dma_sched_state_t;

   typedef enum logic [1:0] {
      RD_IDLE,
      RD_ADDR,
      RD_DATA
   } dma_reader_state_t;

endpackage

`default_nettype wire

// File: include/dma_read_consts.svh
`ifndef DMA_READ_CONSTS_SVH
`define DMA_READ_CONSTS_SVH

// AXI byte address width
`define DMA_ADDR_W 32

// AXI read data and stream word width
`define DMA_DATA_W 32

// log2 of the FIFO depth and of the longest burst (16 beats)
// Also the width of ARLEN
`define DMA_LEN_W 4

// Transfer length in 32-bit words
`define DMA_RLEN_W 16

`endif
